//--- pulse_element.sv
`timescale 1ns/1ps

module pulse_element #(
	parameter int env_bits = qctl_pkg::env_addr_width
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                cmdstb,
	input  logic [qctl_pkg::env_addr_width-1:0] env_start,
	input  logic [qctl_pkg::env_addr_width-1:0] env_len,
	input  logic [qctl_pkg::amp_width-1:0]      amp,
	input  logic [qctl_pkg::freq_width-1:0]     freq,
	input  logic [qctl_pkg::phase_width-1:0]    phase,
	input  logic [qctl_pkg::mode_width-1:0]     mode,
	output logic                                busy,
	output logic                                smp_valid,
	output logic [qctl_pkg::env_addr_width-1:0] smp_env_addr,
	output logic [qctl_pkg::amp_width-1:0]      smp_amp,
	output logic [qctl_pkg::freq_width-1:0]     smp_freq,
	output logic [qctl_pkg::phase_width-1:0]    smp_phase,
	output logic [qctl_pkg::mode_width-1:0]     smp_mode
);

	logic [env_bits-1:0]              remain;
	logic [env_bits-1:0]              addr_q;
	logic [qctl_pkg::amp_width-1:0]   amp_q;
	logic [qctl_pkg::freq_width-1:0]  freq_q;
	logic [qctl_pkg::phase_width-1:0] phase_q;
	logic [qctl_pkg::mode_width-1:0]  mode_q;

	// A new command always wins, so a busy element restarts.
	always_ff @(posedge clk) begin
		if (rst) begin
			remain <= '0;
		end else if (cmdstb) begin
			remain <= env_len[env_bits-1:0];
		end else if (remain != '0) begin
			remain <= remain - 1'b1;
		end
	end

	// The address counter is env_bits wide and wraps on its own.
	always_ff @(posedge clk) begin
		if (cmdstb) begin
			addr_q <= env_start[env_bits-1:0];
			amp_q <= amp;
			freq_q <= freq;
			phase_q <= phase;
			mode_q <= mode;
		end else if (remain != '0) begin
			addr_q <= addr_q + 1'b1;
		end
	end

	assign busy = (remain != '0);
	assign smp_valid = busy;

	always_comb begin
		smp_env_addr = '0;
		smp_env_addr[env_bits-1:0] = addr_q;
	end

	assign smp_amp = amp_q;
	assign smp_freq = freq_q;
	assign smp_phase = phase_q;
	assign smp_mode = mode_q;

endmodule

//--- pulse_route.sv
`timescale 1ns/1ps

module pulse_route (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                pulse_stb,
	input  logic [qctl_pkg::cfg_width-1:0]      pulse_cfg,
	input  logic [qctl_pkg::env_word_width-1:0] pulse_env,
	input  logic [qctl_pkg::amp_width-1:0]      pulse_amp,
	input  logic [qctl_pkg::freq_width-1:0]     pulse_freq,
	input  logic [qctl_pkg::phase_width-1:0]    pulse_phase,
	input  logic                                prog_done,
	input  logic                                qdrv_busy,
	input  logic                                rdrv_busy,
	input  logic                                rdlo_busy,
	output logic                                qdrv_cmdstb,
	output logic [qctl_pkg::env_addr_width-1:0] qdrv_env_start,
	output logic [qctl_pkg::env_addr_width-1:0] qdrv_env_len,
	output logic [qctl_pkg::amp_width-1:0]      qdrv_amp,
	output logic [qctl_pkg::freq_width-1:0]     qdrv_freq,
	output logic [qctl_pkg::phase_width-1:0]    qdrv_phase,
	output logic [qctl_pkg::mode_width-1:0]     qdrv_mode,
	output logic                                rdrv_cmdstb,
	output logic [qctl_pkg::env_addr_width-1:0] rdrv_env_start,
	output logic [qctl_pkg::env_addr_width-1:0] rdrv_env_len,
	output logic [qctl_pkg::amp_width-1:0]      rdrv_amp,
	output logic [qctl_pkg::freq_width-1:0]     rdrv_freq,
	output logic [qctl_pkg::phase_width-1:0]    rdrv_phase,
	output logic [qctl_pkg::mode_width-1:0]     rdrv_mode,
	output logic                                rdlo_cmdstb,
	output logic [qctl_pkg::env_addr_width-1:0] rdlo_env_start,
	output logic [qctl_pkg::env_addr_width-1:0] rdlo_env_len,
	output logic [qctl_pkg::amp_width-1:0]      rdlo_amp,
	output logic [qctl_pkg::freq_width-1:0]     rdlo_freq,
	output logic [qctl_pkg::phase_width-1:0]    rdlo_phase,
	output logic [qctl_pkg::mode_width-1:0]     rdlo_mode,
	output logic                                stbend
);

	localparam int ext_width = qctl_pkg::env_addr_width - qctl_pkg::qdrv_env_width;

	logic [qctl_pkg::chan_width-1:0]     chan;
	logic [qctl_pkg::mode_width-1:0]     mode;
	logic [qctl_pkg::env_addr_width-1:0] env_start;
	logic [qctl_pkg::env_addr_width-1:0] env_len;
	logic [qctl_pkg::env_addr_width-1:0] qdrv_start;
	logic [qctl_pkg::env_addr_width-1:0] qdrv_len;
	logic                                qdrv_sel;
	logic                                rdrv_sel;
	logic                                rdlo_sel;
	logic                                idle;

	assign chan = pulse_cfg[qctl_pkg::chan_width-1:0];
	assign mode = pulse_cfg[qctl_pkg::cfg_width-1:qctl_pkg::chan_width];
	assign env_start = pulse_env[qctl_pkg::env_addr_width-1:0];
	assign env_len = pulse_env[qctl_pkg::env_word_width-1:qctl_pkg::env_addr_width];

	// The qubit drive memory is smaller, so only the low bits are kept.
	assign qdrv_start = {{ext_width{1'b0}}, env_start[qctl_pkg::qdrv_env_width-1:0]};
	assign qdrv_len = {{ext_width{1'b0}}, env_len[qctl_pkg::qdrv_env_width-1:0]};

	assign qdrv_sel = pulse_stb && (chan == qctl_pkg::chan_qdrv);
	assign rdrv_sel = pulse_stb && (chan == qctl_pkg::chan_rdrv);
	assign rdlo_sel = pulse_stb && (chan == qctl_pkg::chan_rdlo);

	always_ff @(posedge clk) begin
		if (rst) begin
			qdrv_cmdstb <= 1'b0;
			rdrv_cmdstb <= 1'b0;
			rdlo_cmdstb <= 1'b0;
			idle <= 1'b0;
		end else begin
			qdrv_cmdstb <= qdrv_sel;
			rdrv_cmdstb <= rdrv_sel;
			rdlo_cmdstb <= rdlo_sel;
			idle <= ~(qdrv_busy | rdrv_busy | rdlo_busy);
		end
	end

	always_ff @(posedge clk) begin
		if (qdrv_sel) begin
			qdrv_env_start <= qdrv_start;
			qdrv_env_len <= qdrv_len;
			qdrv_amp <= pulse_amp;
			qdrv_freq <= pulse_freq;
			qdrv_phase <= pulse_phase;
			qdrv_mode <= mode;
		end
		if (rdrv_sel) begin
			rdrv_env_start <= env_start;
			rdrv_env_len <= env_len;
			rdrv_amp <= pulse_amp;
			rdrv_freq <= pulse_freq;
			rdrv_phase <= pulse_phase;
			rdrv_mode <= mode;
		end
		if (rdlo_sel) begin
			rdlo_env_start <= env_start;
			rdlo_env_len <= env_len;
			rdlo_amp <= pulse_amp;
			rdlo_freq <= pulse_freq;
			rdlo_phase <= pulse_phase;
			rdlo_mode <= mode;
		end
	end

	// The end strobe waits for the program and for every element to drain.
	assign stbend = prog_done & idle;

endmodule

//--- pulse_seq.sv
`timescale 1ns/1ps

module pulse_seq (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [qctl_pkg::cmd_width-1:0]      command,
	output logic [qctl_pkg::cmd_addr_width-1:0] cmd_read_addr,
	output logic                                pulse_stb,
	output logic [qctl_pkg::cfg_width-1:0]      pulse_cfg,
	output logic [qctl_pkg::env_word_width-1:0] pulse_env,
	output logic [qctl_pkg::amp_width-1:0]      pulse_amp,
	output logic [qctl_pkg::freq_width-1:0]     pulse_freq,
	output logic [qctl_pkg::phase_width-1:0]    pulse_phase,
	output logic                                prog_done
);

	typedef enum logic [1:0] {
		st_fetch,
		st_wait,
		st_done
	} state_t;

	state_t                                state;
	logic [qctl_pkg::cmd_addr_width-1:0]   ip;
	logic [qctl_pkg::lat_cnt_width-1:0]    lat_cnt;
	logic [qctl_pkg::wait_width-1:0]       wait_cnt;
	logic [qctl_pkg::wait_width-1:0]       wait_len;
	logic [qctl_pkg::op_width-1:0]         opcode;
	logic                                  issue;
	logic                                  advance;

	assign opcode = command[qctl_pkg::op_pos +: qctl_pkg::op_width];
	assign wait_len = command[qctl_pkg::wait_pos +: qctl_pkg::wait_width];

	// The word on the command bus belongs to ip once the memory latency
	// has been counted out.
	assign issue = (state == st_fetch) &&
		(lat_cnt == qctl_pkg::lat_cnt_width'(qctl_pkg::cmd_mem_latency));

	always_comb begin
		advance = 1'b0;
		if (issue) begin
			case (opcode)
				qctl_pkg::op_wait: advance = (wait_len == '0);
				qctl_pkg::op_done: advance = 1'b0;
				default: advance = 1'b1;
			endcase
		end else if (state == st_wait) begin
			advance = (wait_cnt == qctl_pkg::wait_width'(1));
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_fetch;
			ip <= '0;
			lat_cnt <= '0;
			wait_cnt <= '0;
			prog_done <= 1'b0;
		end else begin
			case (state)
				st_fetch: begin
					if (!issue) begin
						lat_cnt <= lat_cnt + 1'b1;
					end else if (opcode == qctl_pkg::op_done) begin
						prog_done <= 1'b1;
						state <= st_done;
					end else if (opcode == qctl_pkg::op_wait && wait_len != '0) begin
						wait_cnt <= wait_len;
						state <= st_wait;
					end
				end
				st_wait: begin
					wait_cnt <= wait_cnt - 1'b1;
					if (advance) begin
						state <= st_fetch;
					end
				end
				default: begin
					// Program finished, the pointer stays on the DONE word.
					state <= st_done;
				end
			endcase
			if (advance) begin
				ip <= ip + 1'b1;
				lat_cnt <= '0;
			end
		end
	end

	assign cmd_read_addr = ip;

	// The strobe is qualified here; the fields simply follow the bus.
	assign pulse_stb = issue && (opcode == qctl_pkg::op_pulse);
	assign pulse_cfg = command[qctl_pkg::cfg_pos +: qctl_pkg::cfg_width];
	assign pulse_env = command[qctl_pkg::env_pos +: qctl_pkg::env_word_width];
	assign pulse_amp = command[qctl_pkg::amp_pos +: qctl_pkg::amp_width];
	assign pulse_freq = command[qctl_pkg::freq_pos +: qctl_pkg::freq_width];
	assign pulse_phase = command[qctl_pkg::phase_pos +: qctl_pkg::phase_width];

endmodule

//--- qctl_core.f
qctl_pkg.sv
pulse_element.sv
pulse_route.sv
pulse_seq.sv
qctl_core.sv
qctl_core_tb.sv

//--- qctl_core.sv
`timescale 1ns/1ps

module qctl_core (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [qctl_pkg::cmd_width-1:0]      command,
	output logic [qctl_pkg::cmd_addr_width-1:0] cmd_read_addr,
	output logic                                stbend,
	output logic                                prog_done,
	output logic                                qdrv_valid,
	output logic [qctl_pkg::env_addr_width-1:0] qdrv_env_addr,
	output logic [qctl_pkg::amp_width-1:0]      qdrv_amp,
	output logic [qctl_pkg::freq_width-1:0]     qdrv_freq,
	output logic [qctl_pkg::phase_width-1:0]    qdrv_phase,
	output logic [qctl_pkg::mode_width-1:0]     qdrv_mode,
	output logic                                qdrv_busy,
	output logic                                rdrv_valid,
	output logic [qctl_pkg::env_addr_width-1:0] rdrv_env_addr,
	output logic [qctl_pkg::amp_width-1:0]      rdrv_amp,
	output logic [qctl_pkg::freq_width-1:0]     rdrv_freq,
	output logic [qctl_pkg::phase_width-1:0]    rdrv_phase,
	output logic [qctl_pkg::mode_width-1:0]     rdrv_mode,
	output logic                                rdrv_busy,
	output logic                                rdlo_valid,
	output logic [qctl_pkg::env_addr_width-1:0] rdlo_env_addr,
	output logic [qctl_pkg::amp_width-1:0]      rdlo_amp,
	output logic [qctl_pkg::freq_width-1:0]     rdlo_freq,
	output logic [qctl_pkg::phase_width-1:0]    rdlo_phase,
	output logic [qctl_pkg::mode_width-1:0]     rdlo_mode,
	output logic                                rdlo_busy
);

	logic                                pulse_stb;
	logic [qctl_pkg::cfg_width-1:0]      pulse_cfg;
	logic [qctl_pkg::env_word_width-1:0] pulse_env;
	logic [qctl_pkg::amp_width-1:0]      pulse_amp;
	logic [qctl_pkg::freq_width-1:0]     pulse_freq;
	logic [qctl_pkg::phase_width-1:0]    pulse_phase;

	// Per-channel command from the router to its element.
	logic                                qdrv_cmdstb, rdrv_cmdstb, rdlo_cmdstb;
	logic [qctl_pkg::env_addr_width-1:0] qdrv_env_start, rdrv_env_start, rdlo_env_start;
	logic [qctl_pkg::env_addr_width-1:0] qdrv_env_len, rdrv_env_len, rdlo_env_len;
	logic [qctl_pkg::amp_width-1:0]      qdrv_cmd_amp, rdrv_cmd_amp, rdlo_cmd_amp;
	logic [qctl_pkg::freq_width-1:0]     qdrv_cmd_freq, rdrv_cmd_freq, rdlo_cmd_freq;
	logic [qctl_pkg::phase_width-1:0]    qdrv_cmd_phase, rdrv_cmd_phase, rdlo_cmd_phase;
	logic [qctl_pkg::mode_width-1:0]     qdrv_cmd_mode, rdrv_cmd_mode, rdlo_cmd_mode;

	pulse_seq seq_i (
		.clk(clk), .rst(rst), .command(command),
		.cmd_read_addr(cmd_read_addr),
		.pulse_stb(pulse_stb), .pulse_cfg(pulse_cfg), .pulse_env(pulse_env),
		.pulse_amp(pulse_amp), .pulse_freq(pulse_freq), .pulse_phase(pulse_phase),
		.prog_done(prog_done)
	);

	pulse_route route_i (
		.clk(clk), .rst(rst),
		.pulse_stb(pulse_stb), .pulse_cfg(pulse_cfg), .pulse_env(pulse_env),
		.pulse_amp(pulse_amp), .pulse_freq(pulse_freq), .pulse_phase(pulse_phase),
		.prog_done(prog_done),
		.qdrv_busy(qdrv_busy), .rdrv_busy(rdrv_busy), .rdlo_busy(rdlo_busy),
		.qdrv_cmdstb(qdrv_cmdstb), .qdrv_env_start(qdrv_env_start),
		.qdrv_env_len(qdrv_env_len), .qdrv_amp(qdrv_cmd_amp), .qdrv_freq(qdrv_cmd_freq),
		.qdrv_phase(qdrv_cmd_phase), .qdrv_mode(qdrv_cmd_mode),
		.rdrv_cmdstb(rdrv_cmdstb), .rdrv_env_start(rdrv_env_start),
		.rdrv_env_len(rdrv_env_len), .rdrv_amp(rdrv_cmd_amp), .rdrv_freq(rdrv_cmd_freq),
		.rdrv_phase(rdrv_cmd_phase), .rdrv_mode(rdrv_cmd_mode),
		.rdlo_cmdstb(rdlo_cmdstb), .rdlo_env_start(rdlo_env_start),
		.rdlo_env_len(rdlo_env_len), .rdlo_amp(rdlo_cmd_amp), .rdlo_freq(rdlo_cmd_freq),
		.rdlo_phase(rdlo_cmd_phase), .rdlo_mode(rdlo_cmd_mode),
		.stbend(stbend)
	);

	pulse_element #(.env_bits(qctl_pkg::qdrv_env_width)) qdrv_i (
		.clk(clk), .rst(rst), .cmdstb(qdrv_cmdstb),
		.env_start(qdrv_env_start), .env_len(qdrv_env_len),
		.amp(qdrv_cmd_amp), .freq(qdrv_cmd_freq), .phase(qdrv_cmd_phase), .mode(qdrv_cmd_mode),
		.busy(qdrv_busy), .smp_valid(qdrv_valid), .smp_env_addr(qdrv_env_addr),
		.smp_amp(qdrv_amp), .smp_freq(qdrv_freq), .smp_phase(qdrv_phase), .smp_mode(qdrv_mode)
	);

	pulse_element #(.env_bits(qctl_pkg::env_addr_width)) rdrv_i (
		.clk(clk), .rst(rst), .cmdstb(rdrv_cmdstb),
		.env_start(rdrv_env_start), .env_len(rdrv_env_len),
		.amp(rdrv_cmd_amp), .freq(rdrv_cmd_freq), .phase(rdrv_cmd_phase), .mode(rdrv_cmd_mode),
		.busy(rdrv_busy), .smp_valid(rdrv_valid), .smp_env_addr(rdrv_env_addr),
		.smp_amp(rdrv_amp), .smp_freq(rdrv_freq), .smp_phase(rdrv_phase), .smp_mode(rdrv_mode)
	);

	pulse_element #(.env_bits(qctl_pkg::env_addr_width)) rdlo_i (
		.clk(clk), .rst(rst), .cmdstb(rdlo_cmdstb),
		.env_start(rdlo_env_start), .env_len(rdlo_env_len),
		.amp(rdlo_cmd_amp), .freq(rdlo_cmd_freq), .phase(rdlo_cmd_phase), .mode(rdlo_cmd_mode),
		.busy(rdlo_busy), .smp_valid(rdlo_valid), .smp_env_addr(rdlo_env_addr),
		.smp_amp(rdlo_amp), .smp_freq(rdlo_freq), .smp_phase(rdlo_phase), .smp_mode(rdlo_mode)
	);

endmodule

//--- qctl_core_tb.sv
`timescale 1ns/1ps

module qctl_core_tb;

	localparam int num_progs = 4;

	typedef logic [qctl_pkg::env_addr_width-1:0] env_t;
	typedef logic [qctl_pkg::phase_width-1:0]    param_t;
	typedef logic [qctl_pkg::cmd_addr_width-1:0] addr_t;
	typedef logic [qctl_pkg::cmd_width-1:0]      cmd_t;

	typedef struct packed {
		env_t                             addr;
		logic [qctl_pkg::amp_width-1:0]   amp;
		logic [qctl_pkg::freq_width-1:0]  freq;
		logic [qctl_pkg::phase_width-1:0] phase;
		logic [qctl_pkg::mode_width-1:0]  mode;
	} sample_t;

	logic clk, rst, stbend, prog_done;
	cmd_t command;
	addr_t cmd_read_addr;
	logic qdrv_valid, qdrv_busy, rdrv_valid, rdrv_busy, rdlo_valid, rdlo_busy;
	env_t qdrv_env_addr, rdrv_env_addr, rdlo_env_addr;
	logic [qctl_pkg::amp_width-1:0] qdrv_amp, rdrv_amp, rdlo_amp;
	logic [qctl_pkg::freq_width-1:0] qdrv_freq, rdrv_freq, rdlo_freq;
	logic [qctl_pkg::phase_width-1:0] qdrv_phase, rdrv_phase, rdlo_phase;
	logic [qctl_pkg::mode_width-1:0] qdrv_mode, rdrv_mode, rdlo_mode;

	cmd_t mem_pipe [0:qctl_pkg::cmd_mem_latency-1];
	cmd_t prog [0:255];
	sample_t exp_smp [0:3][0:1023];
	int exp_left [0:3][0:1023];
	logic [9:0] exp_head [0:3];
	logic [9:0] exp_tail [0:3];
	int run_left [0:3];
	logic run_end [0:3];
	addr_t prev_addr, done_addr;
	logic [31:0] lfsr;
	int p;

	qctl_core dut_i (.*);

	always #50 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		else
			return s >> 1;
	endfunction

	// Takes n bits from the LFSR and steps it once for each bit.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			r[i] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
		return r;
	endfunction

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_error(input string what);
		$display("%s", what);
		abort_run();
	endtask

	task automatic check_env(input string name, input env_t got, input env_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_param(input string name, input param_t got, input param_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	// Queues the expected samples of one pulse on its channel in order.
	task automatic add_pulse(input logic [3:0] cfg, input env_t start, input env_t len,
			input sample_t fields);
		logic [1:0] ch;
		sample_t s;
		int wrap, base, n, i;
		ch = cfg[1:0];
		if (ch != 2'd3) begin
			wrap = (ch == qctl_pkg::chan_qdrv) ? (1 << qctl_pkg::qdrv_env_width) :
				(1 << qctl_pkg::env_addr_width);
			base = int'(start) % wrap;
			n = int'(len) % wrap;
			s = fields;
			s.mode = cfg[3:2];
			for (i = 0; i < n; i++) begin
				s.addr = env_t'((base + i) % wrap);
				exp_smp[ch][exp_tail[ch]] = s;
				exp_left[ch][exp_tail[ch]] = n - 1 - i;
				exp_tail[ch] = exp_tail[ch] + 1'b1;
			end
		end
	endtask

	function automatic cmd_t make_cmd(input logic [3:0] op, input logic [69:0] payload);
		cmd_t c;
		c = '0;
		c[69:0] = payload;
		c[qctl_pkg::op_pos +: qctl_pkg::op_width] = op;
		return c;
	endfunction

	task automatic gen_program();
		logic [3:0] cfg;
		env_t start, len;
		sample_t f;
		logic [69:0] pl;
		addr_t idx;
		int i, n_items, kind;
		for (i = 0; i < 4; i++) begin
			exp_head[i] = '0;
			exp_tail[i] = '0;
			run_left[i] = 0;
			run_end[i] = 1'b0;
		end
		idx = '0;
		n_items = 10 + int'(rand_bits(3));
		for (i = 0; i <= n_items; i++) begin
			kind = (i == n_items) ? 1 : int'(rand_bits(2));
			pl = {6'(rand_bits(6)), rand_bits(32), rand_bits(32)};
			if (kind == 0) begin
				prog[idx[7:0]] = make_cmd(qctl_pkg::op_nop, pl);
			end else if (kind == 3) begin
				prog[idx[7:0]] = make_cmd(qctl_pkg::op_wait, 70'(rand_bits(3)));
			end else begin
				cfg = 4'(rand_bits(4));
				start = env_t'(rand_bits(12));
				if (rand_bits(2) == 0)
					start[9:4] = '1;
				len = env_t'(rand_bits(5));
				if (i == n_items) begin
					// The last pulse is still playing when DONE arrives.
					if (cfg[1:0] == 2'd3)
						cfg[1:0] = qctl_pkg::chan_rdrv;
					len[4] = 1'b1;
				end
				if (cfg[1:0] == qctl_pkg::chan_qdrv || cfg[1:0] == 2'd3)
					len[11:10] = 2'(rand_bits(2));
				f.amp = 16'(rand_bits(16));
				f.freq = 9'(rand_bits(9));
				f.phase = 17'(rand_bits(17));
				pl = '0;
				pl[qctl_pkg::cfg_pos +: qctl_pkg::cfg_width] = cfg;
				pl[qctl_pkg::env_pos +: qctl_pkg::env_word_width] = {len, start};
				pl[qctl_pkg::amp_pos +: qctl_pkg::amp_width] = f.amp;
				pl[qctl_pkg::freq_pos +: qctl_pkg::freq_width] = f.freq;
				pl[qctl_pkg::phase_pos +: qctl_pkg::phase_width] = f.phase;
				prog[idx[7:0]] = make_cmd(qctl_pkg::op_pulse, pl);
				add_pulse(cfg, start, len, f);
				if (i < n_items) begin
					idx = idx + addr_t'(1);
					pl = 70'(int'(len[9:0]) + 4 + int'(rand_bits(3)));
					prog[idx[7:0]] = make_cmd(qctl_pkg::op_wait, pl);
				end
			end
			idx = idx + addr_t'(1);
		end
		prog[idx[7:0]] = make_cmd(qctl_pkg::op_done, '0);
		done_addr = idx;
	endtask

	// Inside a pulse the element emits one sample every cycle,
	// and it falls idle on the cycle after the last one.
	task automatic check_channel(input string name, input logic [1:0] ch, input logic valid,
			input logic busy, input env_t addr, input sample_t got);
		sample_t e;
		if (run_end[ch]) begin
			check_flag({name, "_busy"}, busy, 1'b0);
			check_flag({name, "_valid"}, valid, 1'b0);
			run_end[ch] = 1'b0;
		end else if (run_left[ch] != 0 || valid || busy) begin
			check_flag({name, "_busy"}, busy, 1'b1);
			check_flag({name, "_valid"}, valid, 1'b1);
			if (exp_head[ch] == exp_tail[ch]) begin
				report_error({name, " produced a sample that no pulse asked for"});
			end else begin
				e = exp_smp[ch][exp_head[ch]];
				run_left[ch] = exp_left[ch][exp_head[ch]];
				run_end[ch] = (run_left[ch] == 0);
				exp_head[ch] = exp_head[ch] + 1'b1;
				check_env({name, "_env_addr"}, addr, e.addr);
				check_param({name, "_amp"}, param_t'(got.amp), param_t'(e.amp));
				check_param({name, "_freq"}, param_t'(got.freq), param_t'(e.freq));
				check_param({name, "_phase"}, got.phase, e.phase);
				check_param({name, "_mode"}, param_t'(got.mode), param_t'(e.mode));
			end
		end
	endtask

	task automatic monitor_outputs();
		if (rst) begin
			check_flag("stbend", stbend, 1'b0);
			check_flag("prog_done", prog_done, 1'b0);
			check_flag("qdrv_valid", qdrv_valid, 1'b0);
			check_flag("rdrv_valid", rdrv_valid, 1'b0);
			check_flag("rdlo_valid", rdlo_valid, 1'b0);
			check_flag("qdrv_busy", qdrv_busy, 1'b0);
			check_flag("rdrv_busy", rdrv_busy, 1'b0);
			check_flag("rdlo_busy", rdlo_busy, 1'b0);
			check_addr("cmd_read_addr", cmd_read_addr, '0);
		end else begin
			if (cmd_read_addr != prev_addr) begin
				if (prev_addr == done_addr)
					report_error("cmd_read_addr moved on past the DONE command");
				check_addr("cmd_read_addr", cmd_read_addr, prev_addr + addr_t'(1));
				prev_addr = cmd_read_addr;
			end
			if (prog_done)
				check_addr("cmd_read_addr", cmd_read_addr, done_addr);
			if (stbend) begin
				check_flag("prog_done", prog_done, 1'b1);
				check_flag("qdrv_busy", qdrv_busy, 1'b0);
				check_flag("rdrv_busy", rdrv_busy, 1'b0);
				check_flag("rdlo_busy", rdlo_busy, 1'b0);
			end
			check_channel("qdrv", 2'd0, qdrv_valid, qdrv_busy, qdrv_env_addr,
				{12'h0, qdrv_amp, qdrv_freq, qdrv_phase, qdrv_mode});
			check_channel("rdrv", 2'd1, rdrv_valid, rdrv_busy, rdrv_env_addr,
				{12'h0, rdrv_amp, rdrv_freq, rdrv_phase, rdrv_mode});
			check_channel("rdlo", 2'd2, rdlo_valid, rdlo_busy, rdlo_env_addr,
				{12'h0, rdlo_amp, rdlo_freq, rdlo_phase, rdlo_mode});
		end
	endtask

	// Checks the outputs once per clock and then drives the command memory.
	task automatic step();
		int i;
		@(negedge clk);
		monitor_outputs();
		for (i = qctl_pkg::cmd_mem_latency - 1; i > 0; i--)
			mem_pipe[i] = mem_pipe[i-1];
		mem_pipe[0] = (cmd_read_addr <= done_addr) ? prog[cmd_read_addr[7:0]] : '0;
		command = mem_pipe[qctl_pkg::cmd_mem_latency-1];
	endtask

	task automatic wait_prog_done();
		int n;
		n = 0;
		while (!prog_done && n < 50000) begin
			step();
			n++;
		end
		if (!prog_done)
			report_error("the program did not reach its DONE command in time");
	endtask

	task automatic wait_stbend();
		int n;
		n = 0;
		while (!stbend && n < 200) begin
			step();
			n++;
		end
		if (!stbend)
			report_error("stbend did not rise after the program finished");
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		command = '0;
		for (p = 0; p < qctl_pkg::cmd_mem_latency; p++)
			mem_pipe[p] = '0;
		lfsr = 32'hecf3_b3e6;
		prev_addr = '0;
		done_addr = '0;
		for (p = 0; p < num_progs; p++) begin
			rst = 1'b1;
			gen_program();
			prev_addr = '0;
			repeat (4) step();
			rst = 1'b0;
			wait_prog_done();
			wait_stbend();
			// Watch a few more cycles for stray samples or address moves.
			repeat (8) step();
			check_flag("stbend", stbend, 1'b1);
			check_addr("cmd_read_addr", cmd_read_addr, done_addr);
			if (exp_head[0] != exp_tail[0] || exp_head[1] != exp_tail[1] ||
					exp_head[2] != exp_tail[2])
				report_error("an element played fewer samples than its pulses asked for");
		end
		$display("All checks passed");
		$finish;
	end

endmodule

//--- qctl_pkg.sv
package qctl_pkg;

	// Command word and command memory.
	localparam int cmd_width = 128;
	localparam int cmd_addr_width = 16;
	localparam int cmd_mem_latency = 2;
	localparam int lat_cnt_width = $clog2(cmd_mem_latency + 1);

	// Pulse payload widths.
	// The packed envelope word holds the start address in the low half
	// and the length in the high half.
	localparam int env_word_width = 24;
	localparam int env_addr_width = 12;
	localparam int qdrv_env_width = 10;
	localparam int phase_width = 17;
	localparam int freq_width = 9;
	localparam int amp_width = 16;
	localparam int wait_width = 16;

	// Config field. Low bits select the channel, high bits carry the mode.
	localparam int cfg_width = 4;
	localparam int chan_width = 2;
	localparam int mode_width = cfg_width - chan_width;

	// Opcode field.
	localparam int op_width = 4;

	// Bit positions inside the command word.
	localparam int op_pos = 124;
	localparam int cfg_pos = 0;
	localparam int env_pos = 4;
	localparam int amp_pos = 28;
	localparam int freq_pos = 44;
	localparam int phase_pos = 53;
	localparam int wait_pos = 0;

	// Opcodes.
	localparam logic [op_width-1:0] op_nop = 4'd0;
	localparam logic [op_width-1:0] op_pulse = 4'd1;
	localparam logic [op_width-1:0] op_wait = 4'd2;
	localparam logic [op_width-1:0] op_done = 4'd3;

	// Channel codes. Code 3 has no element behind it.
	localparam logic [chan_width-1:0] chan_qdrv = 2'd0;
	localparam logic [chan_width-1:0] chan_rdrv = 2'd1;
	localparam logic [chan_width-1:0] chan_rdlo = 2'd2;

endpackage

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module qctl_core_tb -f qctl_core.f -o qctl_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/qctl_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0
